//--- Bender.yml
package:
  name: vic_video

sources:
  - rtl/vic_pkg.sv
  - rtl/raster_if.sv
  - rtl/sprite_cfg_if.sv
  - rtl/raster_counter.sv
  - rtl/vic_regs.sv
  - rtl/sprite_unit.sv
  - rtl/sprite_mixer.sv
  - rtl/vic_video.sv
  - target: test
    files:
      - testbench/tb_vic_video.sv

//--- rtl/raster_counter.sv
`timescale 1ns/10ps

module raster_counter #(
    parameter int H_TOTAL = 64, // pixels per line
    parameter int V_TOTAL = 48  // lines per frame
) (
    input logic       clk_dot4x, // pixel clock, one pixel per cycle
    input logic       arst_n,    // async reset, active low
    raster_if.source  raster     // beam position out
);

    logic [7:0] x_cnt; // horizontal position
    logic [7:0] y_cnt; // vertical position
    logic       x_last; // last pixel of the line
    logic       y_last; // last line of the frame

    assign x_last = (x_cnt == 8'(H_TOTAL - 1));
    assign y_last = (y_cnt == 8'(V_TOTAL - 1));

    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (x_last) begin
            x_cnt <= '0; // wrap and step to next line
            y_cnt <= y_last ? '0 : y_cnt + 8'd1;
        end else begin
            x_cnt <= x_cnt + 8'd1;
        end
    end

    assign raster.x           = x_cnt;
    assign raster.y           = y_cnt;
    assign raster.line_start  = (x_cnt == '0);
    assign raster.frame_start = (x_cnt == '0) && (y_cnt == '0);

    // counters never leave the frame
    a_x_range : assert property (@(posedge clk_dot4x) disable iff (!arst_n)
        x_cnt < 8'(H_TOTAL))
        else $error("raster x out of range: %0d", x_cnt);

    a_y_range : assert property (@(posedge clk_dot4x) disable iff (!arst_n)
        y_cnt < 8'(V_TOTAL))
        else $error("raster y out of range: %0d", y_cnt);

endmodule : raster_counter

//--- rtl/raster_if.sv
`timescale 1ns/10ps

// current beam position, one pixel per clk_dot4x
interface raster_if;

    logic [7:0] x;           // pixel within the line
    logic [7:0] y;           // line within the frame
    logic       line_start;  // x is 0
    logic       frame_start; // x and y are 0

    modport source (
        output x,
        output y,
        output line_start,
        output frame_start
    );

    modport sink (
        input x,
        input y,
        input line_start,
        input frame_start
    );

endinterface : raster_if

//--- rtl/sprite_cfg_if.sv
`timescale 1ns/10ps

// one sprite's settings, register file to sprite unit
interface sprite_cfg_if;

    logic                                   enable;  // sprite shown
    vic_pkg::data_t                         x_pos;   // left column
    vic_pkg::data_t                         y_pos;   // top line
    vic_pkg::color_t                        color;   // palette index of set pixels
    vic_pkg::data_t [vic_pkg::SPR_SIZE-1:0] pattern; // rows 0..7, msb left

    modport source (
        output enable,
        output x_pos,
        output y_pos,
        output color,
        output pattern
    );

    modport sink (
        input enable,
        input x_pos,
        input y_pos,
        input color,
        input pattern
    );

endinterface : sprite_cfg_if

//--- rtl/sprite_mixer.sv
`timescale 1ns/10ps

module sprite_mixer #(
    parameter int NUM_SPRITES = 4 // sprites feeding the mix
) (
    input  logic                                clk_dot4x,     // pixel clock
    input  logic                                arst_n,        // async reset, active low
    raster_if.sink                              raster,        // beam marks
    input  logic [NUM_SPRITES-1:0]              opaque,        // stage one sprite hits
    input  vic_pkg::color_t [NUM_SPRITES-1:0]   colors,        // stage one sprite colors
    input  vic_pkg::color_t                     bg_color,      // fill when no sprite
    output vic_pkg::color_t                     pixel_color,   // final pixel
    output logic                                hsync,         // pixel x is 0
    output logic                                vsync,         // line y is 0
    output logic [NUM_SPRITES-1:0]              collision_set  // overlapping sprites this pixel
);

    localparam int CNT_W = $clog2(NUM_SPRITES + 1); // width of the opaque count

    logic            line_d;    // line_start, stage one
    logic            line0_d;   // beam on line 0, stage one
    vic_pkg::color_t mix_color; // winner before output reg
    logic [CNT_W-1:0] n_opaque; // how many sprites cover the pixel
    logic            multi;     // two or more

    // marks follow the sprite hit registers by one stage
    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            line_d  <= 1'b0;
            line0_d <= 1'b0;
        end else begin
            line_d  <= raster.line_start;
            // set at frame start and cleared at line 1
            line0_d <= raster.frame_start || (line0_d && !raster.line_start);
        end
    end

    always_comb begin
        mix_color = bg_color;
        n_opaque  = '0;
        for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
            if (opaque[i]) mix_color = colors[i]; // lower index overrides
        end
        for (int i = 0; i < NUM_SPRITES; i++) begin
            n_opaque = n_opaque + CNT_W'(opaque[i]);
        end
    end

    assign multi = (n_opaque > CNT_W'(1));

    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            pixel_color   <= '0;
            hsync         <= 1'b0;
            vsync         <= 1'b0;
            collision_set <= '0;
        end else begin
            pixel_color   <= mix_color;
            hsync         <= line_d;
            vsync         <= line0_d;
            collision_set <= multi ? opaque : '0; // lines up with pixel_color
        end
    end

    // a collision always names at least two sprites
    a_no_single : assert property (@(posedge clk_dot4x) disable iff (!arst_n)
        !$onehot(collision_set))
        else $error("collision_set holds a single sprite: %b", collision_set);

endmodule : sprite_mixer

//--- rtl/sprite_unit.sv
`timescale 1ns/10ps

module sprite_unit (
    input  logic            clk_dot4x, // pixel clock
    input  logic            arst_n,    // async reset, active low
    raster_if.sink          raster,    // beam position
    sprite_cfg_if.sink      cfg,       // this sprite's settings
    output logic            opaque,    // set pixel under the beam, stage one
    output vic_pkg::color_t color      // sprite color, stage one
);

    localparam int IDX_W = $clog2(vic_pkg::SPR_SIZE); // row and column index width

    logic [8:0] dx;      // beam minus left edge, 9 bits so left of sprite wraps high
    logic [8:0] dy;      // beam minus top edge
    logic       in_win;  // inside the 8x8 box
    logic       pat_bit; // pattern bit at this spot

    assign dx = {1'b0, raster.x} - {1'b0, cfg.x_pos};
    assign dy = {1'b0, raster.y} - {1'b0, cfg.y_pos};

    assign in_win = (dx < 9'(vic_pkg::SPR_SIZE)) && (dy < 9'(vic_pkg::SPR_SIZE));

    // inverting the column index puts the msb on the left pixel
    assign pat_bit = cfg.pattern[dy[IDX_W-1:0]][~dx[IDX_W-1:0]];

    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            opaque <= 1'b0;
            color  <= '0;
        end else begin
            opaque <= cfg.enable && in_win && pat_bit;
            color  <= cfg.color; // travels alongside opaque
        end
    end

endmodule : sprite_unit

//--- rtl/vic_pkg.sv
package vic_pkg;

    typedef logic [5:0] addr_t;  // register address on the bus
    typedef logic [7:0] data_t;  // bus data byte
    typedef logic [3:0] color_t; // palette index

    localparam int SPR_SIZE    = 8;  // sprite width and height in pixels
    localparam int SPR_REGS    = 12; // register slots per sprite
    localparam int MAX_SPRITES = 4;  // sprites the register map has room for

    // offsets inside one sprite's slot
    localparam int OFS_X      = 0;  // x position
    localparam int OFS_Y      = 1;  // y position
    localparam int OFS_COLOR  = 2;  // color, low nibble
    localparam int OFS_PAT0   = 3;  // pattern row 0, msb is left pixel
    localparam int OFS_UNUSED = 11; // reads zero

    // global registers above the sprite slots
    localparam addr_t REG_ENABLE    = 6'd48; // one enable bit per sprite
    localparam addr_t REG_BG_COLOR  = 6'd49; // background color, low nibble
    localparam addr_t REG_COLLISION = 6'd50; // sprite collision latch, clear on read

endpackage : vic_pkg

//--- rtl/vic_regs.sv
`timescale 1ns/10ps

module vic_regs #(
    parameter int NUM_SPRITES = 4 // sprite units behind this register file
) (
    input  logic                    clk_dot4x,              // pixel clock
    input  logic                    arst_n,                 // async reset, active low
    input  logic                    ce,                     // chip enable, low active
    input  logic                    rw,                     // high read, low write
    input  vic_pkg::addr_t          adi,                    // register address
    input  vic_pkg::data_t          dbi,                    // write data
    output vic_pkg::data_t          dbo,                    // read data, zero when idle
    sprite_cfg_if.source            cfg [NUM_SPRITES],      // per sprite settings out
    input  logic [NUM_SPRITES-1:0]  collision_set,          // new collision bits from mixer
    output vic_pkg::color_t         bg_color,               // background to mixer
    output logic                    irq                     // collision pending
);

    if (NUM_SPRITES < 1 || NUM_SPRITES > vic_pkg::MAX_SPRITES) begin : g_bad_count
        $error("NUM_SPRITES %0d outside 1..%0d", NUM_SPRITES, vic_pkg::MAX_SPRITES);
    end

    vic_pkg::data_t                         x_reg       [NUM_SPRITES];
    vic_pkg::data_t                         y_reg       [NUM_SPRITES];
    vic_pkg::color_t                        color_reg   [NUM_SPRITES];
    vic_pkg::data_t [vic_pkg::SPR_SIZE-1:0] pattern_reg [NUM_SPRITES];
    logic [NUM_SPRITES-1:0]                 enable_reg;    // sprite enables
    vic_pkg::color_t                        bg_reg;        // background color
    logic [NUM_SPRITES-1:0]                 collision_reg; // sticky collision bits

    logic                   wr_en;   // write strobe this cycle
    logic                   rd_en;   // read access this cycle
    logic [NUM_SPRITES-1:0] spr_hit; // address falls in sprite slot
    logic [3:0]             spr_ofs [NUM_SPRITES]; // offset within that slot

    assign wr_en = !ce && !rw;
    assign rd_en = !ce && rw;

    // slot decode, sprite s owns s*12 .. s*12+11
    always_comb begin
        for (int s = 0; s < NUM_SPRITES; s++) begin
            spr_hit[s] = (int'(adi) >= s * vic_pkg::SPR_REGS) &&
                         (int'(adi) < (s + 1) * vic_pkg::SPR_REGS);
            spr_ofs[s] = 4'(int'(adi) - s * vic_pkg::SPR_REGS);
        end
    end

    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SPRITES; s++) begin
                x_reg[s]       <= '0;
                y_reg[s]       <= '0;
                color_reg[s]   <= '0;
                pattern_reg[s] <= '0;
            end
            enable_reg <= '0;
            bg_reg     <= '0;
        end else if (wr_en) begin
            for (int s = 0; s < NUM_SPRITES; s++) begin
                if (spr_hit[s]) begin
                    if (spr_ofs[s] == 4'(vic_pkg::OFS_X)) x_reg[s] <= dbi;
                    if (spr_ofs[s] == 4'(vic_pkg::OFS_Y)) y_reg[s] <= dbi;
                    if (spr_ofs[s] == 4'(vic_pkg::OFS_COLOR)) color_reg[s] <= dbi[3:0];
                    if (spr_ofs[s] >= 4'(vic_pkg::OFS_PAT0) &&
                        spr_ofs[s] < 4'(vic_pkg::OFS_UNUSED)) begin
                        pattern_reg[s][3'(spr_ofs[s] - 4'(vic_pkg::OFS_PAT0))] <= dbi;
                    end
                end
            end
            if (adi == vic_pkg::REG_ENABLE) enable_reg <= dbi[NUM_SPRITES-1:0];
            if (adi == vic_pkg::REG_BG_COLOR) bg_reg <= dbi[3:0];
        end
    end

    // latch collisions, read clears but same-cycle arrivals survive
    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            collision_reg <= '0;
        end else if (rd_en && adi == vic_pkg::REG_COLLISION) begin
            collision_reg <= collision_set;
        end else begin
            collision_reg <= collision_reg | collision_set;
        end
    end

    assign irq = |collision_reg; // high while anything latched

    always_comb begin
        dbo = '0; // bus idle or unmapped address
        if (rd_en) begin
            for (int s = 0; s < NUM_SPRITES; s++) begin
                if (spr_hit[s]) begin
                    if (spr_ofs[s] == 4'(vic_pkg::OFS_X)) dbo = x_reg[s];
                    if (spr_ofs[s] == 4'(vic_pkg::OFS_Y)) dbo = y_reg[s];
                    if (spr_ofs[s] == 4'(vic_pkg::OFS_COLOR)) dbo[3:0] = color_reg[s];
                    if (spr_ofs[s] >= 4'(vic_pkg::OFS_PAT0) &&
                        spr_ofs[s] < 4'(vic_pkg::OFS_UNUSED)) begin
                        dbo = pattern_reg[s][3'(spr_ofs[s] - 4'(vic_pkg::OFS_PAT0))];
                    end
                end
            end
            if (adi == vic_pkg::REG_ENABLE) dbo[NUM_SPRITES-1:0] = enable_reg;
            if (adi == vic_pkg::REG_BG_COLOR) dbo[3:0] = bg_reg;
            if (adi == vic_pkg::REG_COLLISION) dbo[NUM_SPRITES-1:0] = collision_reg;
        end
    end

    for (genvar s = 0; s < NUM_SPRITES; s++) begin : g_cfg
        assign cfg[s].enable  = enable_reg[s];
        assign cfg[s].x_pos   = x_reg[s];
        assign cfg[s].y_pos   = y_reg[s];
        assign cfg[s].color   = color_reg[s];
        assign cfg[s].pattern = pattern_reg[s];
    end

    assign bg_color = bg_reg;

    a_adi_known : assert property (@(posedge clk_dot4x) disable iff (!arst_n)
        !ce |-> !$isunknown(adi))
        else $error("unknown address during bus access");

endmodule : vic_regs

//--- rtl/vic_video.sv
`timescale 1ns/10ps

module vic_video #(
    parameter int NUM_SPRITES = 4,  // 1..MAX_SPRITES
    parameter int H_TOTAL     = 64, // pixels per line
    parameter int V_TOTAL     = 48  // lines per frame
) (
    input  logic            clk_dot4x,   // pixel clock
    input  logic            arst_n,      // async reset, active low
    input  logic            ce,          // chip enable, low active
    input  logic            rw,          // high read, low write
    input  vic_pkg::addr_t  adi,         // register address
    input  vic_pkg::data_t  dbi,         // bus write data
    output vic_pkg::data_t  dbo,         // bus read data
    output vic_pkg::color_t pixel_color, // pixel out, two cycles behind raster
    output logic            hsync,       // first pixel of a line
    output logic            vsync,       // whole of line 0
    output logic            irq          // sprite collision pending
);

    raster_if     raster ();
    sprite_cfg_if cfg_bus [NUM_SPRITES] ();

    logic [NUM_SPRITES-1:0]            spr_opaque;    // gathered unit hits
    vic_pkg::color_t [NUM_SPRITES-1:0] spr_color;     // gathered unit colors
    logic [NUM_SPRITES-1:0]            collision_set; // mixer to latch
    vic_pkg::color_t                   bg_color;      // register to mixer

    raster_counter #(
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL)
    ) raster_inst (
        .clk_dot4x(clk_dot4x),
        .arst_n(arst_n),
        .raster(raster)
    );

    vic_regs #(
        .NUM_SPRITES(NUM_SPRITES)
    ) regs_inst (
        .clk_dot4x(clk_dot4x),
        .arst_n(arst_n),
        .ce(ce),
        .rw(rw),
        .adi(adi),
        .dbi(dbi),
        .dbo(dbo),
        .cfg(cfg_bus),
        .collision_set(collision_set),
        .bg_color(bg_color),
        .irq(irq)
    );

    for (genvar s = 0; s < NUM_SPRITES; s++) begin : g_sprite
        sprite_unit sprite_inst (
            .clk_dot4x(clk_dot4x),
            .arst_n(arst_n),
            .raster(raster),
            .cfg(cfg_bus[s]),
            .opaque(spr_opaque[s]),
            .color(spr_color[s])
        );
    end

    sprite_mixer #(
        .NUM_SPRITES(NUM_SPRITES)
    ) mixer_inst (
        .clk_dot4x(clk_dot4x),
        .arst_n(arst_n),
        .raster(raster),
        .opaque(spr_opaque),
        .colors(spr_color),
        .bg_color(bg_color),
        .pixel_color(pixel_color),
        .hsync(hsync),
        .vsync(vsync),
        .collision_set(collision_set)
    );

endmodule : vic_video

//--- testbench/tb_vic_video.sv
`timescale 1ns/10ps

module tb_vic_video;

    localparam int NUM_SPRITES    = 4;  // dut defaults
    localparam int H_TOTAL        = 64;
    localparam int V_TOTAL        = 48;
    localparam int HALF_PERIOD    = 50; // 100 ns clock
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = 6 * 3 * H_TOTAL * V_TOTAL + RESET_CYCLES; // 6 tests of 3 frames

    logic            clk_dot4x;
    logic            arst_n;
    logic            ce;
    logic            rw;
    vic_pkg::addr_t  adi;
    vic_pkg::data_t  dbi;
    vic_pkg::data_t  dbo;
    vic_pkg::color_t pixel_color;
    logic            hsync;
    logic            vsync;
    logic            irq;

    vic_pkg::data_t mirror [64];                // expected register contents
    logic [31:0]    lfsr_state = 32'hbbe9_523a; // random source
    int             errors;
    int             checks;
    int             cycles;

    vic_video i_dut (
        .clk_dot4x(clk_dot4x),
        .arst_n(arst_n),
        .ce(ce),
        .rw(rw),
        .adi(adi),
        .dbi(dbi),
        .dbo(dbo),
        .pixel_color(pixel_color),
        .hsync(hsync),
        .vsync(vsync),
        .irq(irq)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #HALF_PERIOD clk_dot4x = ~clk_dot4x;
    end

    always @(posedge clk_dot4x) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state); // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // reference pixel from window, pattern and priority rules
    function automatic vic_pkg::color_t model_pixel(input int px, input int py,
                                                    output logic [NUM_SPRITES-1:0] opq);
        vic_pkg::color_t col;
        vic_pkg::data_t  row;
        int              base;
        int              cx;
        int              cy;
        col = mirror[vic_pkg::REG_BG_COLOR][3:0]; // fill when nothing opaque
        opq = '0;
        for (int s = 0; s < NUM_SPRITES; s++) begin
            base = s * vic_pkg::SPR_REGS;
            cx   = px - int'(mirror[base + vic_pkg::OFS_X]);
            cy   = py - int'(mirror[base + vic_pkg::OFS_Y]);
            if (mirror[vic_pkg::REG_ENABLE][s] && cx >= 0 && cx < vic_pkg::SPR_SIZE &&
                cy >= 0 && cy < vic_pkg::SPR_SIZE) begin
                row = mirror[base + vic_pkg::OFS_PAT0 + cy];
                if (row[7 - cx]) begin // msb is the left pixel
                    if (opq == '0) col = mirror[base + vic_pkg::OFS_COLOR][3:0]; // first wins
                    opq[s] = 1'b1;
                end
            end
        end
        return col;
    endfunction

    task automatic compare_value(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
            else begin
                $display("ERR %s %s expected %0h actual %0h", test, what, exp, act);
                errors++;
            end
    endtask

    // one-cycle write starting and ending on a falling edge
    task automatic set_reg(input int addr, input vic_pkg::data_t v);
        int ofs;
        ce  = 1'b0;
        rw  = 1'b0;
        adi = vic_pkg::addr_t'(addr);
        dbi = v;
        if (addr < NUM_SPRITES * vic_pkg::SPR_REGS) begin
            ofs = addr % vic_pkg::SPR_REGS;
            if (ofs == vic_pkg::OFS_COLOR) mirror[addr] = v & 8'h0f;
            else if (ofs == vic_pkg::OFS_UNUSED) mirror[addr] = '0;
            else mirror[addr] = v;
        end else if (addr == vic_pkg::REG_ENABLE) begin
            mirror[addr] = v & 8'((1 << NUM_SPRITES) - 1); // only real sprites
        end else if (addr == vic_pkg::REG_BG_COLOR) begin
            mirror[addr] = v & 8'h0f;
        end
        @(negedge clk_dot4x);
        ce = 1'b1;
        rw = 1'b1;
    endtask

    task automatic read_reg(input int addr, output vic_pkg::data_t v);
        ce  = 1'b0;
        rw  = 1'b1;
        adi = vic_pkg::addr_t'(addr);
        #(HALF_PERIOD / 2) v = dbo; // dbo settled well before the rising edge
        @(negedge clk_dot4x);
        ce = 1'b1;
    endtask

    task automatic place_sprite(input int s, input int x, input int y, input vic_pkg::data_t fill);
        int base;
        base = s * vic_pkg::SPR_REGS;
        set_reg(base + vic_pkg::OFS_X, 8'(x));
        set_reg(base + vic_pkg::OFS_Y, 8'(y));
        set_reg(base + vic_pkg::OFS_COLOR, 8'(rand_bits(4)));
        for (int r = 0; r < vic_pkg::SPR_SIZE; r++) begin
            set_reg(base + vic_pkg::OFS_PAT0 + r, 8'(rand_bits(8)) | fill);
        end
    endtask

    // returns with output at pixel (0, V_TOTAL-1)
    task automatic wait_last_line();
        logic prev;
        int   line;
        do begin
            prev = vsync;
            @(negedge clk_dot4x);
        end while (!(vsync && !prev));
        line = 0;
        while (line < V_TOTAL - 1) begin
            @(negedge clk_dot4x);
            if (hsync) line++;
        end
    endtask

    // lock to vsync then compare a whole frame against the model
    task automatic scan_frame(input string test, output logic [NUM_SPRITES-1:0] coll);
        logic                   prev;
        logic                   coll_prev;
        logic [NUM_SPRITES-1:0] opq;
        vic_pkg::color_t        exp_col;
        coll      = '0;
        coll_prev = 1'b0;
        do begin
            prev = vsync;
            @(negedge clk_dot4x);
        end while (!(vsync && !prev));
        for (int y = 0; y < V_TOTAL; y++) begin
            for (int x = 0; x < H_TOTAL; x++) begin
                if (x != 0 || y != 0) @(negedge clk_dot4x);
                exp_col = model_pixel(x, y, opq);
                compare_value(test, $sformatf("pixel (%0d,%0d)", x, y), exp_col, pixel_color);
                compare_value(test, $sformatf("hsync (%0d,%0d)", x, y), x == 0, hsync);
                compare_value(test, $sformatf("vsync (%0d,%0d)", x, y), y == 0, vsync);
                checks++;
                assert (!coll_prev || irq)
                    else begin
                        $display("%s: irq still low one cycle after collision at (%0d,%0d)",
                                 test, x, y);
                        errors++;
                    end
                coll_prev = ($countones(opq) > 1); // overlap of opaque pixels
                if (coll_prev) coll |= opq;
            end
        end
    endtask

    task automatic report_test(input string name, input int start);
        $display("test %-10s %s, %0d errors", name, (errors == start) ? "ok" : "failed",
                 errors - start);
    endtask

    initial begin
        logic [NUM_SPRITES-1:0] mask;
        vic_pkg::data_t         rd;
        int                     start;
        int                     bx;
        int                     by;
        ce     = 1'b1;
        rw     = 1'b1;
        adi    = '0;
        dbi    = '0;
        arst_n = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        foreach (mirror[i]) mirror[i] = '0; // reset values
        repeat (RESET_CYCLES) @(negedge clk_dot4x);
        arst_n = 1'b1;

        start = errors;
        for (int a = 0; a <= vic_pkg::REG_BG_COLOR; a++) set_reg(a, 8'(rand_bits(8)));
        for (int a = 0; a <= vic_pkg::REG_BG_COLOR; a++) begin
            read_reg(a, rd);
            compare_value("readback", $sformatf("reg %0d", a), mirror[a], rd);
        end
        report_test("readback", start);

        start = errors;
        wait_last_line();
        set_reg(vic_pkg::REG_ENABLE, 8'h00);
        set_reg(vic_pkg::REG_BG_COLOR, 8'(rand_bits(4)));
        scan_frame("background", mask);
        report_test("background", start);

        start = errors;
        bx    = int'(rand_bits(2)) % NUM_SPRITES; // the one sprite shown
        wait_last_line();
        place_sprite(bx, rand_bits(6), rand_bits(6), 8'h00); // may clip at the edges
        set_reg(vic_pkg::REG_ENABLE, 8'(1 << bx));
        set_reg(vic_pkg::REG_BG_COLOR, 8'(rand_bits(4)));
        scan_frame("single", mask);
        report_test("single", start);

        start = errors;
        bx    = rand_bits(5);
        by    = rand_bits(5);
        wait_last_line();
        for (int s = 0; s < NUM_SPRITES; s++) begin
            place_sprite(s, bx + rand_bits(2), by + rand_bits(2), 8'h00);
        end
        set_reg(vic_pkg::REG_ENABLE, 8'hff);
        scan_frame("priority", mask);
        report_test("priority", start);

        start = errors;
        wait_last_line();
        set_reg(vic_pkg::REG_ENABLE, 8'h00);
        wait_last_line();
        read_reg(vic_pkg::REG_COLLISION, rd); // drop stale bits
        for (int s = 0; s < NUM_SPRITES; s++) begin
            place_sprite(s, bx + rand_bits(1), by + rand_bits(1), 8'h3c);
        end
        set_reg(vic_pkg::REG_ENABLE, 8'hff);
        scan_frame("collision", mask);
        compare_value("collision", "irq after overlap", 1, irq);
        wait_last_line();
        set_reg(vic_pkg::REG_ENABLE, 8'h00);
        wait_last_line();
        read_reg(vic_pkg::REG_COLLISION, rd);
        compare_value("collision", "latch read", mask, rd);
        compare_value("collision", "irq after clear", 0, irq);
        read_reg(vic_pkg::REG_COLLISION, rd);
        compare_value("collision", "second read", 0, rd);
        for (int s = 0; s < NUM_SPRITES; s++) begin
            place_sprite(s, s * 16 + rand_bits(3), rand_bits(5), 8'h00);
        end
        set_reg(vic_pkg::REG_ENABLE, 8'hff);
        scan_frame("collision", mask);
        compare_value("collision", "irq without overlap", 0, irq);
        report_test("collision", start);

        start = errors;
        for (int round = 0; round < 2; round++) begin
            wait_last_line();
            for (int s = 0; s < NUM_SPRITES; s++) begin
                place_sprite(s, rand_bits(6), rand_bits(6), 8'h00);
            end
            set_reg(vic_pkg::REG_ENABLE, 8'(rand_bits(8)));
            scan_frame("enable", mask);
        end
        report_test("enable", start);

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_vic_video

//--- vlog.f
rtl/vic_pkg.sv
rtl/raster_if.sv
rtl/sprite_cfg_if.sv
rtl/raster_counter.sv
rtl/vic_regs.sv
rtl/sprite_unit.sv
rtl/sprite_mixer.sv
rtl/vic_video.sv
testbench/tb_vic_video.sv
